// File: source/des_pkg.sv
`default_nettype none

package des_pkg;

	localparam int des_rounds   = 16;  // Feistel rounds per block
	localparam int des_block_w  = 64;
	localparam int des_half_w   = 32;
	localparam int des_key_w    = 64;  // Parity bits included, never checked
	localparam int des_cd_w     = 28;  // C and D halves after PC1
	localparam int des_subkey_w = 48;
	localparam int des_cnt_w    = 4;   // Round counter

	// Entries are 1-based source bit numbers, bit 1 is the MSB as in the standard
	// Entry k drives output bit k counted from the LSB, upper entries unused
	typedef logic [63:0][7:0] perm_table_t;

	localparam perm_table_t ip_table = {
		8'd58, 8'd50, 8'd42, 8'd34, 8'd26, 8'd18, 8'd10, 8'd2,
		8'd60, 8'd52, 8'd44, 8'd36, 8'd28, 8'd20, 8'd12, 8'd4,
		8'd62, 8'd54, 8'd46, 8'd38, 8'd30, 8'd22, 8'd14, 8'd6,
		8'd64, 8'd56, 8'd48, 8'd40, 8'd32, 8'd24, 8'd16, 8'd8,
		8'd57, 8'd49, 8'd41, 8'd33, 8'd25, 8'd17, 8'd9,  8'd1,
		8'd59, 8'd51, 8'd43, 8'd35, 8'd27, 8'd19, 8'd11, 8'd3,
		8'd61, 8'd53, 8'd45, 8'd37, 8'd29, 8'd21, 8'd13, 8'd5,
		8'd63, 8'd55, 8'd47, 8'd39, 8'd31, 8'd23, 8'd15, 8'd7
	};

	localparam perm_table_t fp_table = {  // Inverse of IP
		8'd40, 8'd8, 8'd48, 8'd16, 8'd56, 8'd24, 8'd64, 8'd32,
		8'd39, 8'd7, 8'd47, 8'd15, 8'd55, 8'd23, 8'd63, 8'd31,
		8'd38, 8'd6, 8'd46, 8'd14, 8'd54, 8'd22, 8'd62, 8'd30,
		8'd37, 8'd5, 8'd45, 8'd13, 8'd53, 8'd21, 8'd61, 8'd29,
		8'd36, 8'd4, 8'd44, 8'd12, 8'd52, 8'd20, 8'd60, 8'd28,
		8'd35, 8'd3, 8'd43, 8'd11, 8'd51, 8'd19, 8'd59, 8'd27,
		8'd34, 8'd2, 8'd42, 8'd10, 8'd50, 8'd18, 8'd58, 8'd26,
		8'd33, 8'd1, 8'd41, 8'd9,  8'd49, 8'd17, 8'd57, 8'd25
	};

	localparam perm_table_t e_table = {{16{8'd0}},  // 32 to 48 bit expansion
		8'd32, 8'd1,  8'd2,  8'd3,  8'd4,  8'd5,
		8'd4,  8'd5,  8'd6,  8'd7,  8'd8,  8'd9,
		8'd8,  8'd9,  8'd10, 8'd11, 8'd12, 8'd13,
		8'd12, 8'd13, 8'd14, 8'd15, 8'd16, 8'd17,
		8'd16, 8'd17, 8'd18, 8'd19, 8'd20, 8'd21,
		8'd20, 8'd21, 8'd22, 8'd23, 8'd24, 8'd25,
		8'd24, 8'd25, 8'd26, 8'd27, 8'd28, 8'd29,
		8'd28, 8'd29, 8'd30, 8'd31, 8'd32, 8'd1
	};

	localparam perm_table_t p_table = {{32{8'd0}},
		8'd16, 8'd7,  8'd20, 8'd21, 8'd29, 8'd12, 8'd28, 8'd17,
		8'd1,  8'd15, 8'd23, 8'd26, 8'd5,  8'd18, 8'd31, 8'd10,
		8'd2,  8'd8,  8'd24, 8'd14, 8'd32, 8'd27, 8'd3,  8'd9,
		8'd19, 8'd13, 8'd30, 8'd6,  8'd22, 8'd11, 8'd4,  8'd25
	};

	// PC1 drops the parity bits 8, 16 .. 64
	localparam perm_table_t pc1_table = {{8{8'd0}},
		8'd57, 8'd49, 8'd41, 8'd33, 8'd25, 8'd17, 8'd9,
		8'd1,  8'd58, 8'd50, 8'd42, 8'd34, 8'd26, 8'd18,
		8'd10, 8'd2,  8'd59, 8'd51, 8'd43, 8'd35, 8'd27,
		8'd19, 8'd11, 8'd3,  8'd60, 8'd52, 8'd44, 8'd36,
		8'd63, 8'd55, 8'd47, 8'd39, 8'd31, 8'd23, 8'd15,
		8'd7,  8'd62, 8'd54, 8'd46, 8'd38, 8'd30, 8'd22,
		8'd14, 8'd6,  8'd61, 8'd53, 8'd45, 8'd37, 8'd29,
		8'd21, 8'd13, 8'd5,  8'd28, 8'd20, 8'd12, 8'd4
	};

	localparam perm_table_t pc2_table = {{16{8'd0}},  // Bit numbers within C:D
		8'd14, 8'd17, 8'd11, 8'd24, 8'd1,  8'd5,
		8'd3,  8'd28, 8'd15, 8'd6,  8'd21, 8'd10,
		8'd23, 8'd19, 8'd12, 8'd4,  8'd26, 8'd8,
		8'd16, 8'd7,  8'd27, 8'd20, 8'd13, 8'd2,
		8'd41, 8'd52, 8'd31, 8'd37, 8'd47, 8'd55,
		8'd30, 8'd40, 8'd51, 8'd45, 8'd33, 8'd48,
		8'd44, 8'd49, 8'd39, 8'd56, 8'd34, 8'd53,
		8'd46, 8'd42, 8'd50, 8'd36, 8'd29, 8'd32
	};

	// S1 first, each box row-major with index row*16 + col
	localparam logic [0:7][0:63][3:0] sbox_table = {
		64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
		64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D,
		64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
		64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9,
		64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
		64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C,
		64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
		64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E,
		64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
		64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453,
		64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
		64'h9EF528C3704A1DB6, 64'h432C95FABE17608D,
		64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
		64'h14BDC37EAF680592, 64'h6BD814A7950FE23C,
		64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
		64'h7B419CE206ADF358, 64'h21E74A8DFC90356B
	};

	localparam logic [0:15][1:0] shift_table = {  // Left rotations, round 1 first
		2'd1, 2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2,
		2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd1
	};

	// Input right aligned in din, result right aligned in the return value
	function automatic logic [63:0] des_permute(
		input logic [63:0] din,
		input int in_w,
		input perm_table_t tbl,
		input int out_w
	);
		logic [63:0] dout;
		dout = '0;
		for (int k = 0; k < 64; k++) begin
			if (k < out_w) begin
				dout[k] = din[in_w - int'(tbl[k])];  // Bit n sits at in_w - n
			end
		end
		return dout;
	endfunction

endpackage

`default_nettype wire

// File: source/des_regs_pkg.sv
`default_nettype none

package des_regs_pkg;

	localparam int apb_addr_w = 5;
	localparam int apb_data_w = 32;

	// Byte addresses, word aligned
	localparam logic [apb_addr_w-1:0] reg_ctrl    = 5'h00;  // Write only
	localparam logic [apb_addr_w-1:0] reg_status  = 5'h04;  // Read only
	localparam logic [apb_addr_w-1:0] reg_key_hi  = 5'h08;
	localparam logic [apb_addr_w-1:0] reg_key_lo  = 5'h0C;
	localparam logic [apb_addr_w-1:0] reg_data_hi = 5'h10;
	localparam logic [apb_addr_w-1:0] reg_data_lo = 5'h14;
	localparam logic [apb_addr_w-1:0] reg_res_hi  = 5'h18;  // Read only
	localparam logic [apb_addr_w-1:0] reg_res_lo  = 5'h1C;  // Read only

	localparam int ctrl_start_bit  = 0;
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;  // Sticky until next start

endpackage

`default_nettype wire

// File: source/des_key_schedule.sv
`timescale 1ns/10ps
`default_nettype none

module des_key_schedule (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	input  wire logic                            load,     // Same cycle as accepted start
	input  wire logic                            advance,  // High in each round cycle
	input  wire logic [des_pkg::des_key_w-1:0]   key,
	output logic      [des_pkg::des_subkey_w-1:0] subkey
);
	import des_pkg::*;

	logic [des_cd_w-1:0]    c_q, d_q;      // Rotated state up to previous round
	logic [des_cd_w-1:0]    c_rot, d_rot;  // State for the current round
	logic [des_cnt_w-1:0]   round_idx;
	logic [1:0]             shift_amt;
	logic [des_key_w-1:0]   pc1_out;
	logic [des_key_w-1:0]   pc2_out;

	function automatic logic [des_cd_w-1:0] rotate_left(
		input logic [des_cd_w-1:0] cd,
		input logic [1:0]          amt
	);
		if (amt == 2'd2) begin
			return {cd[des_cd_w-3:0], cd[des_cd_w-1 -: 2]};
		end
		return {cd[des_cd_w-2:0], cd[des_cd_w-1]};
	endfunction

	assign pc1_out   = des_permute(key, des_key_w, pc1_table, 2 * des_cd_w);
	assign shift_amt = shift_table[round_idx];
	assign c_rot     = rotate_left(c_q, shift_amt);
	assign d_rot     = rotate_left(d_q, shift_amt);

	// PC2 over the 56-bit C:D, zero padded to the function width
	assign pc2_out = des_permute({{(des_key_w - 2 * des_cd_w){1'b0}}, c_rot, d_rot},
		2 * des_cd_w, pc2_table, des_subkey_w);
	assign subkey  = pc2_out[des_subkey_w-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_idx <= '0;
		end else if (load) begin
			round_idx <= '0;
		end else if (advance) begin
			round_idx <= round_idx + 1'b1;  // Wraps to 0 after round 16
		end
	end

	always_ff @(posedge clk) begin  // C and D payload
		if (load) begin
			c_q <= pc1_out[2*des_cd_w-1:des_cd_w];
			d_q <= pc1_out[des_cd_w-1:0];
		end else if (advance) begin
			c_q <= c_rot;
			d_q <= d_rot;
		end
	end

endmodule

`default_nettype wire

// File: source/des_round.sv
`timescale 1ns/10ps
`default_nettype none

module des_round (
	input  wire logic [des_pkg::des_half_w-1:0]   l_in,
	input  wire logic [des_pkg::des_half_w-1:0]   r_in,
	input  wire logic [des_pkg::des_subkey_w-1:0] subkey,
	output logic      [des_pkg::des_half_w-1:0]   l_out,
	output logic      [des_pkg::des_half_w-1:0]   r_out
);
	import des_pkg::*;

	logic [des_block_w-1:0]  e_full;    // Expansion, right aligned
	logic [des_block_w-1:0]  p_full;
	logic [des_subkey_w-1:0] mixed;     // E(R) xor K
	logic [des_half_w-1:0]   sbox_out;

	assign e_full = des_permute(des_block_w'(r_in), des_half_w, e_table, des_subkey_w);
	assign mixed  = e_full[des_subkey_w-1:0] ^ subkey;

	always_comb begin : sbox_lookup
		logic [5:0] six;
		sbox_out = '0;
		for (int s = 0; s < 8; s++) begin
			six = mixed[des_subkey_w-1 - 6*s -: 6];  // S1 takes the top six bits
			// Row from outer bits, column from the middle four
			sbox_out[des_half_w-1 - 4*s -: 4] = sbox_table[s][{six[5], six[0], six[4:1]}];
		end
	end

	assign p_full = des_permute(des_block_w'(sbox_out), des_half_w, p_table, des_half_w);

	assign l_out = r_in;
	assign r_out = l_in ^ p_full[des_half_w-1:0];

endmodule

`default_nettype wire

// File: source/des_encryption.sv
`timescale 1ns/10ps
`default_nettype none

module des_encryption (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             start,
	input  wire logic [des_pkg::des_block_w-1:0]  message,
	input  wire logic [des_pkg::des_subkey_w-1:0] subkey,
	output logic                                  load_key,
	output logic                                  advance_key,
	output logic                                  busy,
	output logic                                  done,    // One cycle after round 16
	output logic      [des_pkg::des_block_w-1:0]  result
);
	import des_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_round,
		st_finished
	} state_t;

	state_t                 state, next_state;
	logic [des_cnt_w-1:0]   round_cnt;  // Rounds done so far in st_round
	logic [des_block_w-1:0] block_q;    // L:R working block
	logic [des_block_w-1:0] ip_block;
	logic [des_half_w-1:0]  l_next, r_next;
	logic                   start_acc;
	logic                   last_round;

	assign start_acc  = start && (state == st_idle);  // Ignored unless idle
	assign last_round = (round_cnt == des_cnt_w'(des_rounds - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle:     if (start_acc) next_state = st_round;
			st_round:    if (last_round) next_state = st_finished;
			st_finished: next_state = st_idle;  // Done pulse lasts one cycle
			default:     next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_cnt <= '0;
		end else if (start_acc) begin
			round_cnt <= '0;
		end else if (state == st_round) begin
			round_cnt <= round_cnt + 1'b1;
		end
	end

	assign ip_block = des_permute(message, des_block_w, ip_table, des_block_w);

	des_round u_round (
		.l_in   (block_q[des_block_w-1:des_half_w]),
		.r_in   (block_q[des_half_w-1:0]),
		.subkey (subkey),
		.l_out  (l_next),
		.r_out  (r_next)
	);

	always_ff @(posedge clk) begin
		if (start_acc) begin
			block_q <= ip_block;  // IP at the accepting edge
		end else if (state == st_round) begin
			block_q <= {l_next, r_next};
		end
	end

	// Final swap R16:L16 before FP, held in block_q until the next start
	assign result = des_permute({block_q[des_half_w-1:0], block_q[des_block_w-1:des_half_w]},
		des_block_w, fp_table, des_block_w);

	assign load_key    = start_acc;
	assign advance_key = (state == st_round);
	assign busy        = (state != st_idle);  // Covers the done cycle too
	assign done        = (state == st_finished);

endmodule

`default_nettype wire

// File: source/des_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module des_apb_regs (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  wire logic                                psel,
	input  wire logic                                penable,
	input  wire logic                                pwrite,
	input  wire logic [des_regs_pkg::apb_addr_w-1:0] paddr,
	input  wire logic [des_regs_pkg::apb_data_w-1:0] pwdata,
	input  wire logic                                busy,
	input  wire logic                                done,
	input  wire logic [des_pkg::des_block_w-1:0]     result,
	output logic      [des_regs_pkg::apb_data_w-1:0] prdata,
	output logic                                     pready,
	output logic                                     pslverr,
	output logic                                     start,  // Pulse on completed ctrl write
	output logic      [des_pkg::des_key_w-1:0]       key,
	output logic      [des_pkg::des_block_w-1:0]     message
);
	import des_regs_pkg::*;

	logic [apb_data_w-1:0] key_hi, key_lo;
	logic [apb_data_w-1:0] data_hi, data_lo;
	logic [apb_data_w-1:0] res_hi, res_lo;
	logic [apb_data_w-1:0] status_word;
	logic                  done_q;  // Sticky done
	logic                  access;
	logic                  hit_ctrl, hit_status, hit_key_hi, hit_key_lo;
	logic                  hit_data_hi, hit_data_lo, hit_res_hi, hit_res_lo;
	logic                  hit_core_cfg;  // Registers the core depends on
	logic                  bad_access;
	logic                  wr_ok;

	assign access = psel && penable;

	assign hit_ctrl    = (paddr == reg_ctrl);
	assign hit_status  = (paddr == reg_status);
	assign hit_key_hi  = (paddr == reg_key_hi);
	assign hit_key_lo  = (paddr == reg_key_lo);
	assign hit_data_hi = (paddr == reg_data_hi);
	assign hit_data_lo = (paddr == reg_data_lo);
	assign hit_res_hi  = (paddr == reg_res_hi);
	assign hit_res_lo  = (paddr == reg_res_lo);

	assign hit_core_cfg = hit_ctrl || hit_key_hi || hit_key_lo || hit_data_hi || hit_data_lo;

	// Unmapped, or a write to a read-only register
	assign bad_access = !(hit_core_cfg || hit_status || hit_res_hi || hit_res_lo) ||
		(pwrite && (hit_status || hit_res_hi || hit_res_lo));

	assign pready  = !(access && pwrite && busy && hit_core_cfg);  // Hold config writes
	assign pslverr = access && pready && bad_access;
	assign wr_ok   = access && pwrite && pready && !bad_access;
	assign start   = wr_ok && hit_ctrl && pwdata[ctrl_start_bit];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_hi  <= '0;
			key_lo  <= '0;
			data_hi <= '0;
			data_lo <= '0;
		end else if (wr_ok) begin
			if (hit_key_hi) key_hi <= pwdata;
			if (hit_key_lo) key_lo <= pwdata;
			if (hit_data_hi) data_hi <= pwdata;
			if (hit_data_lo) data_lo <= pwdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_hi <= '0;
			res_lo <= '0;
			done_q <= 1'b0;
		end else if (start) begin
			done_q <= 1'b0;  // Cleared by a new job
		end else if (done) begin
			{res_hi, res_lo} <= result;
			done_q           <= 1'b1;
		end
	end

	always_comb begin
		status_word                  = '0;
		status_word[status_busy_bit] = busy;
		status_word[status_done_bit] = done_q;
	end

	always_comb begin  // Read mux, ctrl reads as zero
		case (paddr)
			reg_status:  prdata = status_word;
			reg_key_hi:  prdata = key_hi;
			reg_key_lo:  prdata = key_lo;
			reg_data_hi: prdata = data_hi;
			reg_data_lo: prdata = data_lo;
			reg_res_hi:  prdata = res_hi;
			reg_res_lo:  prdata = res_lo;
			default:     prdata = '0;
		endcase
	end

	assign key     = {key_hi, key_lo};
	assign message = {data_hi, data_lo};  // Stable while the core runs

endmodule

`default_nettype wire

// File: source/des_top.sv
`timescale 1ns/10ps
`default_nettype none

module des_top (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  wire logic                                psel,
	input  wire logic                                penable,
	input  wire logic                                pwrite,
	input  wire logic [des_regs_pkg::apb_addr_w-1:0] paddr,
	input  wire logic [des_regs_pkg::apb_data_w-1:0] pwdata,
	output logic      [des_regs_pkg::apb_data_w-1:0] prdata,
	output logic                                     pready,
	output logic                                     pslverr
);
	import des_pkg::*;

	logic                    start;
	logic                    busy, done;
	logic                    load_key, advance_key;
	logic [des_key_w-1:0]    key;
	logic [des_block_w-1:0]  message;
	logic [des_block_w-1:0]  result;
	logic [des_subkey_w-1:0] subkey;  // Current round key

	des_apb_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.busy    (busy),
		.done    (done),
		.result  (result),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.start   (start),
		.key     (key),
		.message (message)
	);

	des_encryption u_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.message     (message),
		.subkey      (subkey),
		.load_key    (load_key),
		.advance_key (advance_key),
		.busy        (busy),
		.done        (done),
		.result      (result)
	);

	des_key_schedule u_keys (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load_key),
		.advance (advance_key),
		.key     (key),
		.subkey  (subkey)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int half_period  = 20;  // 40 ns period
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);  // Release away from the active edge
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/des_chk.sv
`timescale 1ns/10ps
`default_nettype none

module des_chk (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,     // APB start pulse
	input wire logic load_key,  // Start accepted by the core
	input wire logic busy,
	input wire logic done,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr
);
	int fail_count = 0;  // Assertion failures so far

	// Exactly 17 cycles from accepted start to done, in both directions
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		load_key |-> ##17 done)
		else begin
			fail_count++;
			$error("done not seen 17 cycles after an accepted start");
		end

	a_done_source: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(load_key, 17))
		else begin
			fail_count++;
			$error("done without an accepted start 17 cycles before");
		end

	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !busy && !done && !start)
		else begin
			fail_count++;
			$error("busy, done or start high during reset");
		end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy)  // Ctrl writes are held while busy
		else begin
			fail_count++;
			$error("start pulse while the core is busy");
		end

	a_slverr_phase: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> psel && penable && pready)
		else begin
			fail_count++;
			$error("pslverr outside a completing access cycle");
		end

endmodule

// Top level sees both the APB side and the core handshake
bind des_top des_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.start    (start),
	.load_key (load_key),
	.busy     (busy),
	.done     (done),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.pslverr  (pslverr)
);

`default_nettype wire

// File: tests/des_tb.sv
`timescale 1ns/10ps
`default_nettype none

module des_tb;
	import des_regs_pkg::*;

	localparam int ready_limit = 64;  // Access cycles per transfer
	localparam int poll_limit  = 40;  // Status reads per job

	// Known answers
	localparam logic [63:0] key_a    = 64'h1334_5779_9BBC_DFF1;
	localparam logic [63:0] plain_a  = 64'h0123_4567_89AB_CDEF;
	localparam logic [63:0] cipher_a = 64'h85E8_1354_0F0A_B405;
	localparam logic [63:0] key_b    = 64'h0E32_9232_EA6D_0D73;
	localparam logic [63:0] plain_b  = 64'h8787_8787_8787_8787;
	localparam logic [63:0] cipher_b = 64'h0000_0000_0000_0000;

	logic                  clk, rst_n;
	logic                  psel, penable, pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic                  pready, pslverr;

	int                    seed = 5;
	int                    err_count = 0;
	int                    err_at_start = 0;
	int                    tests_passed = 0;
	int                    tests_failed = 0;
	int                    chk_failures;
	int                    wait_cycles;
	logic [apb_data_w-1:0] rd_word;
	logic                  rd_err;
	logic [apb_data_w-1:0] rand_words [4];  // key hi, key lo, data hi, data lo

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	des_top u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	task automatic give_up(input string what);
		$display("%0t timeout while waiting for %s", $time, what);
		$display("Test failed");
		$finish;
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			err_count++;
			$display("ERR %0t %s: got %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	// One APB transfer, inputs change on the falling edge, outputs seen at the rising edge
	task automatic apb_access(input logic write, input logic [apb_addr_w-1:0] addr,
		input logic [apb_data_w-1:0] data, output logic [apb_data_w-1:0] rdata,
		output logic err, output int waits);
		waits = 0;
		@(negedge clk);
		psel    = 1'b1;  // Setup phase
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);  // First access edge
		while (!pready && waits < ready_limit) begin
			@(posedge clk);
			waits++;
		end
		if (!pready) begin
			give_up("pready");
		end
		rdata = prdata;  // Values at the completing edge
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input logic [apb_addr_w-1:0] addr, input logic [apb_data_w-1:0] data);
		logic [apb_data_w-1:0] rdata;
		logic                  err;
		int                    waits;
		apb_access(1'b1, addr, data, rdata, err, waits);
		check_word("pslverr on write", {31'b0, err}, 32'h0);
	endtask

	task automatic expect_read(input string what, input logic [apb_addr_w-1:0] addr,
		input logic [apb_data_w-1:0] exp);
		logic [apb_data_w-1:0] rdata;
		logic                  err;
		int                    waits;
		apb_access(1'b0, addr, '0, rdata, err, waits);
		check_word(what, rdata, exp);
		check_word({what, " pslverr"}, {31'b0, err}, 32'h0);
	endtask

	task automatic expect_slverr(input string what, input logic write,
		input logic [apb_addr_w-1:0] addr);
		logic [apb_data_w-1:0] rdata;
		logic                  err;
		int                    waits;
		apb_access(write, addr, 32'hFFFF_FFFF, rdata, err, waits);  // All ones incl. start bit
		check_word(what, {31'b0, err}, 32'h1);
	endtask

	task automatic wait_for_done();
		logic [apb_data_w-1:0] status;
		logic                  err;
		int                    waits;
		int                    polls;
		polls  = 0;
		status = '0;
		while (!status[status_done_bit] && polls < poll_limit) begin
			apb_access(1'b0, reg_status, '0, status, err, waits);
			polls++;
		end
		if (!status[status_done_bit]) begin
			give_up("status done bit");
		end
	endtask

	task automatic load_job(input logic [63:0] key, input logic [63:0] block);
		write_reg(reg_key_hi, key[63:32]);
		write_reg(reg_key_lo, key[31:0]);
		write_reg(reg_data_hi, block[63:32]);
		write_reg(reg_data_lo, block[31:0]);
	endtask

	task automatic expect_result(input logic [63:0] exp);
		expect_read("result hi", reg_res_hi, exp[63:32]);
		expect_read("result lo", reg_res_lo, exp[31:0]);
	endtask

	task automatic end_test(input string name);
		if (err_count == err_at_start) begin
			tests_passed++;
			$display("%0t test %s: ok", $time, name);
		end else begin
			tests_failed++;
			$display("%0t test %s: FAIL, %0d errors", $time, name, err_count - err_at_start);
		end
		err_at_start = err_count;
	endtask

	initial begin : stimulus
		int n;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		n       = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			give_up("reset release");
		end

		// Everything readable is zero out of reset
		expect_read("ctrl", reg_ctrl, '0);
		expect_read("status", reg_status, '0);
		expect_read("key hi", reg_key_hi, '0);
		expect_read("key lo", reg_key_lo, '0);
		expect_read("data hi", reg_data_hi, '0);
		expect_read("data lo", reg_data_lo, '0);
		expect_result('0);
		end_test("reset_values");

		for (int i = 0; i < 4; i++) begin
			rand_words[i] = $random(seed);
		end
		write_reg(reg_key_hi, rand_words[0]);
		write_reg(reg_key_lo, rand_words[1]);
		write_reg(reg_data_hi, rand_words[2]);
		write_reg(reg_data_lo, rand_words[3]);
		expect_read("key hi", reg_key_hi, rand_words[0]);
		expect_read("key lo", reg_key_lo, rand_words[1]);
		expect_read("data hi", reg_data_hi, rand_words[2]);
		expect_read("data lo", reg_data_lo, rand_words[3]);
		expect_result('0);  // No job run yet
		end_test("register_readback");

		load_job(key_a, plain_a);
		write_reg(reg_ctrl, 32'h1);
		wait_for_done();
		expect_result(cipher_a);
		end_test("known_answer_a");

		load_job(key_b, plain_b);
		write_reg(reg_ctrl, 32'h1);
		expect_read("status after start", reg_status, 32'h1 << status_busy_bit);  // Done cleared
		wait_for_done();
		expect_result(cipher_b);
		end_test("known_answer_b");

		// Data write right behind the start must wait for the block
		load_job(key_a, plain_a);
		write_reg(reg_ctrl, 32'h1);
		apb_access(1'b1, reg_data_hi, plain_b[63:32], rd_word, rd_err, wait_cycles);
		assert (wait_cycles > 0) else begin
			err_count++;
			$display("ERR %0t data write during busy was not held", $time);
		end
		check_word("held write pslverr", {31'b0, rd_err}, 32'h0);
		expect_read("status after held write", reg_status, 32'h1 << status_done_bit);
		expect_result(cipher_a);  // Plaintext unchanged under the running job
		write_reg(reg_key_hi, key_b[63:32]);
		write_reg(reg_key_lo, key_b[31:0]);
		write_reg(reg_data_lo, plain_b[31:0]);
		write_reg(reg_ctrl, 32'h1);
		wait_for_done();
		expect_result(cipher_b);
		expect_read("data hi after held write", reg_data_hi, plain_b[63:32]);
		end_test("back_pressure");

		// 5-bit map, so out of map means unaligned offsets
		expect_slverr("unmapped read", 1'b0, 5'h1E);
		expect_slverr("unmapped write", 1'b1, 5'h1E);
		expect_slverr("unaligned write near ctrl", 1'b1, 5'h01);
		expect_slverr("unaligned write near key", 1'b1, 5'h0A);
		expect_slverr("status write", 1'b1, reg_status);
		expect_slverr("result hi write", 1'b1, reg_res_hi);
		expect_slverr("result lo write", 1'b1, reg_res_lo);
		expect_read("status kept", reg_status, 32'h1 << status_done_bit);  // No stray start
		expect_read("key hi kept", reg_key_hi, key_b[63:32]);
		expect_read("key lo kept", reg_key_lo, key_b[31:0]);
		expect_read("data hi kept", reg_data_hi, plain_b[63:32]);
		expect_read("data lo kept", reg_data_lo, plain_b[31:0]);
		expect_result(cipher_b);
		end_test("error_responses");

		chk_failures = u_dut.u_chk.fail_count;  // Bound checker in the DUT
		$display("%0t tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
			$time, tests_passed, tests_failed, err_count, chk_failures);
		if (tests_failed == 0 && chk_failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
source/des_pkg.sv
source/des_regs_pkg.sv
source/des_key_schedule.sv
source/des_round.sv
source/des_encryption.sv
source/des_apb_regs.sv
source/des_top.sv
tests/tb_clock.sv
tests/des_chk.sv
tests/des_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the DES APB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module des_tb

# Bound assertions count their failures, so the run must go on past the first one
out=$(./obj_dir/Vdes_tb +verilator+error+limit+1000 2>&1)
echo "$out"

echo "$out" | grep -q "Test completed successfully"
